//--- Makefile
TOP = tb_equalizer

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -f build.f

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -Wall \
		--top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir sim.log

//--- build.f
rtl/eq_pkg.sv
rtl/eq_regs.sv
rtl/chan_estimator.sv
rtl/data_equalizer.sv
rtl/equalizer_top.sv
tb/equalizer_asserts.sv
tb/tb_equalizer.sv

//--- rtl/chan_estimator.sv
`default_nettype none

module chan_estimator (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         enable_i,
    input  logic                         restart_i,
    input  logic                         sample_stb_i,
    input  logic [2*eq_pkg::IQ_W-1:0]    sample_i,
    input  eq_pkg::sc_idx_t              chan_addr_i,
    output eq_pkg::iq_t                  chan_i_o,
    output eq_pkg::iq_t                  chan_q_o,
    output logic                         trained_o
);

    localparam eq_pkg::sc_idx_t LAST_IDX = eq_pkg::sc_idx_t'(eq_pkg::NUM_SC - 1);

    logic [2*eq_pkg::IQ_W-1:0] ram [eq_pkg::NUM_SC];
    logic [2*eq_pkg::IQ_W-1:0] ram_q;
    logic [2*eq_pkg::IQ_W-1:0] wr_data;

    eq_pkg::est_state_t state;
    eq_pkg::sc_idx_t    cnt;
    eq_pkg::sc_idx_t    rd_addr;
    eq_pkg::sc_idx_t    wr_addr;
    eq_pkg::sc_idx_t    avg_addr;
    eq_pkg::iq_t        lts_i_q;
    eq_pkg::iq_t        lts_q_q;
    eq_pkg::iq_t        half_i;
    eq_pkg::iq_t        half_q;
    eq_pkg::iq_t        avg_i;
    eq_pkg::iq_t        avg_q;
    logic signed [eq_pkg::IQ_W:0] sum_i;
    logic signed [eq_pkg::IQ_W:0] sum_q;
    logic avg_vld;
    logic neg_q;
    logic last_avg;
    logic take;
    logic wr_en;

    // the cycle holding the last average blocks a stray strobe from starting a 65th
    assign last_avg = avg_vld && (avg_addr == LAST_IDX);
    assign take     = enable_i && sample_stb_i && !last_avg;

    assign chan_i_o  = ram_q[2*eq_pkg::IQ_W-1:eq_pkg::IQ_W];
    assign chan_q_o  = ram_q[eq_pkg::IQ_W-1:0];
    assign trained_o = (state == eq_pkg::EST_TRAINED);

    // mean of the two LTS, sign flipped by the reference
    always_comb begin
        sum_i  = chan_i_o + lts_i_q;
        sum_q  = chan_q_o + lts_q_q;
        half_i = sum_i[eq_pkg::IQ_W:1];
        half_q = sum_q[eq_pkg::IQ_W:1];
        avg_i  = neg_q ? -half_i : half_i;
        avg_q  = neg_q ? -half_q : half_q;
    end

    assign wr_en   = avg_vld || (state == eq_pkg::EST_FIRST_LTS && take);
    assign wr_addr = avg_vld ? avg_addr : cnt;
    assign wr_data = avg_vld ? {avg_i, avg_q} : sample_i;
    assign rd_addr = trained_o ? chan_addr_i : cnt;

    always_ff @(posedge clock) begin
        if (reset || restart_i) begin
            state   <= eq_pkg::EST_FIRST_LTS;
            cnt     <= '0;
            avg_vld <= 1'b0;
        end else begin
            avg_vld <= 1'b0;
            case (state)
                eq_pkg::EST_FIRST_LTS: begin
                    if (take) begin
                        cnt <= cnt + 1'b1;
                        if (cnt == LAST_IDX)
                            state <= eq_pkg::EST_SECOND_LTS;
                    end
                end
                eq_pkg::EST_SECOND_LTS: begin
                    if (take) begin
                        cnt     <= cnt + 1'b1;
                        avg_vld <= 1'b1;
                    end
                    if (last_avg)
                        state <= eq_pkg::EST_TRAINED;
                end
                eq_pkg::EST_TRAINED: begin
                end
                default: state <= eq_pkg::EST_FIRST_LTS;
            endcase
        end
    end

    // second LTS sample waits one cycle for the stored first LTS
    always_ff @(posedge clock) begin
        if (take && state == eq_pkg::EST_SECOND_LTS) begin
            avg_addr <= cnt;
            lts_i_q  <= sample_i[2*eq_pkg::IQ_W-1:eq_pkg::IQ_W];
            lts_q_q  <= sample_i[eq_pkg::IQ_W-1:0];
            neg_q    <= eq_pkg::LTS_REF[cnt];
        end
    end

    always_ff @(posedge clock) begin
        if (wr_en)
            ram[wr_addr] <= wr_data;
        ram_q <= ram[rd_addr];
    end

endmodule

`default_nettype wire

//--- rtl/data_equalizer.sv
`default_nettype none

module data_equalizer (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         enable_i,
    input  logic                         trained_i,
    input  logic                         sample_stb_i,
    input  logic [2*eq_pkg::IQ_W-1:0]    sample_i,
    input  eq_pkg::scale_t               scale_i,
    input  eq_pkg::iq_t                  chan_i_i,
    input  eq_pkg::iq_t                  chan_q_i,
    output eq_pkg::sc_idx_t              chan_addr_o,
    output logic [2*eq_pkg::IQ_W-1:0]    sample_o,
    output logic                         sample_stb_o,
    output logic [7:0]                   sym_count_o
);

    localparam eq_pkg::sc_idx_t LAST_IDX = eq_pkg::sc_idx_t'(eq_pkg::NUM_SC - 1);

    eq_pkg::sc_idx_t idx;
    eq_pkg::iq_t     x_i_q;
    eq_pkg::iq_t     x_q_q;
    logic            mask_q;
    logic            vld_q;
    logic            take;
    logic signed [2*eq_pkg::IQ_W:0] acc_i;
    logic signed [2*eq_pkg::IQ_W:0] acc_q;
    logic signed [2*eq_pkg::IQ_W:0] shf_i;
    logic signed [2*eq_pkg::IQ_W:0] shf_q;

    assign take        = enable_i && trained_i && sample_stb_i;
    assign chan_addr_o = idx;

    // stage 1: running subcarrier index and symbol counter
    always_ff @(posedge clock) begin
        if (reset) begin
            idx         <= '0;
            vld_q       <= 1'b0;
            sym_count_o <= '0;
        end else begin
            vld_q <= take;
            if (!trained_i) begin
                idx <= '0;
            end else if (take) begin
                idx <= idx + 1'b1;
                if (idx == LAST_IDX)
                    sym_count_o <= sym_count_o + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            x_i_q  <= sample_i[2*eq_pkg::IQ_W-1:eq_pkg::IQ_W];
            x_q_q  <= sample_i[eq_pkg::IQ_W-1:0];
            mask_q <= eq_pkg::DATA_SC_MASK[idx];
        end
    end

    // stage 2: x * conj(h), estimate arrives one cycle after the address
    always_comb begin
        acc_i = x_i_q * chan_i_i + x_q_q * chan_q_i;
        acc_q = x_q_q * chan_i_i - x_i_q * chan_q_i;
        shf_i = acc_i >>> scale_i;
        shf_q = acc_q >>> scale_i;
    end

    always_ff @(posedge clock) begin
        if (reset)
            sample_stb_o <= 1'b0;
        else
            sample_stb_o <= vld_q && mask_q;
    end

    always_ff @(posedge clock) begin
        if (vld_q)
            sample_o <= {shf_i[eq_pkg::IQ_W-1:0], shf_q[eq_pkg::IQ_W-1:0]};
    end

endmodule

`default_nettype wire

//--- rtl/eq_pkg.sv
`default_nettype none

package eq_pkg;

    localparam int NUM_SC   = 64;
    localparam int SC_IDX_W = 6;
    localparam int IQ_W     = 16;

    // bit k is the k-th sample of a symbol: 0 is DC, 1..26 positive, 38..63 negative
    localparam logic [NUM_SC-1:0] LTS_REF =
        64'b0000101001100000010100110000000000000000010101100111110101001100;

    // legacy subcarriers with the four pilots (+-7, +-21) removed
    localparam logic [NUM_SC-1:0] DATA_SC_MASK =
        64'b1111111111111111111111111100000000000111111111111111111111111110 ^
        64'b0000001000000000000010000000000000000000001000000000000010000000;

    localparam int SCALE_W = 4;
    localparam logic [SCALE_W-1:0] SCALE_RESET = 4'd8;

    localparam int WB_ADR_W = 2;
    localparam int WB_DAT_W = 32;

    typedef logic signed [IQ_W-1:0] iq_t;
    typedef logic [SC_IDX_W-1:0] sc_idx_t;
    typedef logic [SCALE_W-1:0] scale_t;

    typedef enum logic [1:0] {
        EST_FIRST_LTS,
        EST_SECOND_LTS,
        EST_TRAINED
    } est_state_t;

    // word addresses of the register block
    typedef enum logic [WB_ADR_W-1:0] {
        REG_CTRL   = 2'd0,
        REG_SCALE  = 2'd1,
        REG_STATUS = 2'd2
    } reg_addr_t;

endpackage

`default_nettype wire

//--- rtl/eq_regs.sv
`default_nettype none

module eq_regs (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         wb_cyc_i,
    input  logic                         wb_stb_i,
    input  logic                         wb_we_i,
    input  logic [eq_pkg::WB_ADR_W-1:0]  wb_adr_i,
    input  logic [eq_pkg::WB_DAT_W-1:0]  wb_dat_i,
    output logic [eq_pkg::WB_DAT_W-1:0]  wb_dat_o,
    output logic                         wb_ack_o,
    input  logic                         trained_i,
    input  logic [7:0]                   sym_count_i,
    output logic                         enable_o,
    output logic                         restart_o,
    output eq_pkg::scale_t               scale_o
);

    logic wb_req;
    logic wb_wr;

    // new request: cycle open, strobe high, not yet acknowledged
    assign wb_req = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign wb_wr  = wb_req && wb_we_i;

    always_ff @(posedge clock) begin
        if (reset) begin
            wb_ack_o  <= 1'b0;
            enable_o  <= 1'b0;
            restart_o <= 1'b0;
            scale_o   <= eq_pkg::SCALE_RESET;
        end else begin
            wb_ack_o  <= wb_req;
            restart_o <= 1'b0;
            if (wb_wr) begin
                case (eq_pkg::reg_addr_t'(wb_adr_i))
                    eq_pkg::REG_CTRL: begin
                        enable_o  <= wb_dat_i[0];
                        restart_o <= wb_dat_i[1];
                    end
                    eq_pkg::REG_SCALE: begin
                        scale_o <= wb_dat_i[eq_pkg::SCALE_W-1:0];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // read data lines up with ack
    always_ff @(posedge clock) begin
        if (wb_req) begin
            case (eq_pkg::reg_addr_t'(wb_adr_i))
                eq_pkg::REG_CTRL: begin
                    wb_dat_o <= eq_pkg::WB_DAT_W'(enable_o);
                end
                eq_pkg::REG_SCALE: begin
                    wb_dat_o <= eq_pkg::WB_DAT_W'(scale_o);
                end
                eq_pkg::REG_STATUS: begin
                    wb_dat_o <= eq_pkg::WB_DAT_W'({sym_count_i, 7'd0, trained_i});
                end
                default: begin
                    wb_dat_o <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/equalizer_top.sv
`default_nettype none

module equalizer_top (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         wb_cyc_i,
    input  logic                         wb_stb_i,
    input  logic                         wb_we_i,
    input  logic [eq_pkg::WB_ADR_W-1:0]  wb_adr_i,
    input  logic [eq_pkg::WB_DAT_W-1:0]  wb_dat_i,
    output logic [eq_pkg::WB_DAT_W-1:0]  wb_dat_o,
    output logic                         wb_ack_o,
    input  logic [2*eq_pkg::IQ_W-1:0]    sample_i,
    input  logic                         sample_stb_i,
    output logic [2*eq_pkg::IQ_W-1:0]    sample_o,
    output logic                         sample_stb_o
);

    logic            enable;
    logic            restart;
    logic            trained;
    logic [7:0]      sym_count;
    eq_pkg::scale_t  scale;
    eq_pkg::sc_idx_t chan_addr;
    eq_pkg::iq_t     chan_i;
    eq_pkg::iq_t     chan_q;

    eq_regs u_regs (
        .clock       (clock),
        .reset       (reset),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .trained_i   (trained),
        .sym_count_i (sym_count),
        .enable_o    (enable),
        .restart_o   (restart),
        .scale_o     (scale)
    );

    chan_estimator u_est (
        .clock        (clock),
        .reset        (reset),
        .enable_i     (enable),
        .restart_i    (restart),
        .sample_stb_i (sample_stb_i),
        .sample_i     (sample_i),
        .chan_addr_i  (chan_addr),
        .chan_i_o     (chan_i),
        .chan_q_o     (chan_q),
        .trained_o    (trained)
    );

    data_equalizer u_eq (
        .clock        (clock),
        .reset        (reset),
        .enable_i     (enable),
        .trained_i    (trained),
        .sample_stb_i (sample_stb_i),
        .sample_i     (sample_i),
        .scale_i      (scale),
        .chan_i_i     (chan_i),
        .chan_q_i     (chan_q),
        .chan_addr_o  (chan_addr),
        .sample_o     (sample_o),
        .sample_stb_o (sample_stb_o),
        .sym_count_o  (sym_count)
    );

endmodule

`default_nettype wire

//--- tb/equalizer_asserts.sv
`default_nettype none

module equalizer_asserts (
    input logic clock,
    input logic reset,
    input logic wb_cyc_i,
    input logic wb_stb_i,
    input logic wb_ack_i,
    input logic sample_stb_i,
    input logic trained_i
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;

    ack_needs_request: assert property (@(posedge clock) disable iff (reset)
        wb_ack_i |-> wb_cyc_i && wb_stb_i)
    else begin
        fail_count++;
        $error("wishbone ack without cyc and stb");
    end

    ack_single_cycle: assert property (@(posedge clock) disable iff (reset)
        wb_ack_i |=> !wb_ack_i)
    else begin
        fail_count++;
        $error("wishbone ack high for two cycles");
    end

    // output strobe only from items taken while trained
    output_after_training: assert property (@(posedge clock) disable iff (reset)
        sample_stb_i |-> $past(trained_i, 2))
    else begin
        fail_count++;
        $error("output strobe without a trained estimate");
    end

endmodule

bind equalizer_top equalizer_asserts u_asserts (
    .clock        (clock),
    .reset        (reset),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_ack_i     (wb_ack_o),
    .sample_stb_i (sample_stb_o),
    .trained_i    (trained)
);

`default_nettype wire

//--- tb/tb_equalizer.sv
`default_nettype none

module tb_equalizer;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT = 1000;

    logic                        clock;
    logic                        reset;
    logic                        wb_cyc_i;
    logic                        wb_stb_i;
    logic                        wb_we_i;
    logic [eq_pkg::WB_ADR_W-1:0] wb_adr_i;
    logic [eq_pkg::WB_DAT_W-1:0] wb_dat_i;
    logic [eq_pkg::WB_DAT_W-1:0] wb_dat_o;
    logic                        wb_ack_o;
    logic [2*eq_pkg::IQ_W-1:0]   sample_i;
    logic                        sample_stb_i;
    logic [2*eq_pkg::IQ_W-1:0]   sample_o;
    logic                        sample_stb_o;

    // reference model state
    eq_pkg::iq_t               est_i [eq_pkg::NUM_SC];
    eq_pkg::iq_t               est_q [eq_pkg::NUM_SC];
    logic [2*eq_pkg::IQ_W-1:0] exp_q [$];
    logic [2*eq_pkg::IQ_W-1:0] got_q [$];
    eq_pkg::scale_t            scale;
    int                        symbols;
    int                        errors;
    int                        test_errors;
    int                        tests;
    int                        failed_tests;
    bit                        timed_out;
    logic [eq_pkg::WB_DAT_W-1:0] rdata;

    equalizer_top DUT (
        .clock        (clock),
        .reset        (reset),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .sample_i     (sample_i),
        .sample_stb_i (sample_stb_i),
        .sample_o     (sample_o),
        .sample_stb_o (sample_stb_o)
    );

    always #4 clock = ~clock;

    // outputs are sampled on the falling edge while they are stable
    always @(negedge clock) begin
        if (sample_stb_o === 1'b1)
            got_q.push_back(sample_o);
    end

    task automatic check_iq(input string name, input eq_pkg::iq_t expected,
                            input eq_pkg::iq_t actual);
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_word(input string name, input logic [eq_pkg::WB_DAT_W-1:0] expected,
                              input logic [eq_pkg::WB_DAT_W-1:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    task automatic wb_transfer(input logic we, input eq_pkg::reg_addr_t addr,
                               input logic [31:0] wdata, output logic [31:0] data);
        int n;
        n = 0;
        data = '0;
        if (timed_out)
            return;
        @(negedge clock);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = addr;
        wb_dat_i = wdata;
        do begin
            @(negedge clock);
            n++;
        end while (wb_ack_o !== 1'b1 && n < WAIT_LIMIT);
        if (wb_ack_o !== 1'b1) begin
            errors++;
            timed_out = 1'b1;
            $display("timeout: the register block never acknowledged address %0d", addr);
        end
        data = wb_dat_o;
        // cycle ends on the edge that samples ack
        @(negedge clock);
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic reg_write(input eq_pkg::reg_addr_t addr, input logic [31:0] wdata);
        logic [31:0] unused;
        wb_transfer(1'b1, addr, wdata, unused);
    endtask

    task automatic reg_read(input eq_pkg::reg_addr_t addr, output logic [31:0] data);
        wb_transfer(1'b0, addr, '0, data);
    endtask

    function automatic logic [31:0] status_word(input logic trained);
        return 32'({8'(symbols), 7'd0, trained});
    endfunction

    // one component in -4096..4096
    function automatic eq_pkg::iq_t random_iq();
        return eq_pkg::iq_t'($urandom_range(8192, 0)) - 16'sd4096;
    endfunction

    // x * conj(h) with an arithmetic shift and the low 16 bits kept
    function automatic logic [31:0] equalize(input logic [31:0] x, input int k);
        longint xi;
        longint xq;
        longint yi;
        longint yq;
        xi = eq_pkg::iq_t'(x[31:16]);
        xq = eq_pkg::iq_t'(x[15:0]);
        yi = (xi * longint'(est_i[k]) + xq * longint'(est_q[k])) >>> scale;
        yq = (xq * longint'(est_i[k]) - xi * longint'(est_q[k])) >>> scale;
        return {yi[15:0], yq[15:0]};
    endfunction

    task automatic drive_sample(input logic [31:0] word);
        @(negedge clock);
        sample_i     = word;
        sample_stb_i = 1'b1;
    endtask

    task automatic idle(input int cycles);
        for (int n = 0; n < cycles; n++) begin
            @(negedge clock);
            sample_stb_i = 1'b0;
        end
    endtask

    task automatic train(input string name);
        logic [31:0] lts1 [eq_pkg::NUM_SC];
        logic [31:0] lts2;
        int          sum_i;
        int          sum_q;
        for (int k = 0; k < eq_pkg::NUM_SC; k++) begin
            lts1[k] = {random_iq(), random_iq()};
            drive_sample(lts1[k]);
        end
        idle($urandom_range(2, 0));
        for (int k = 0; k < eq_pkg::NUM_SC; k++) begin
            lts2  = {random_iq(), random_iq()};
            sum_i = int'(eq_pkg::iq_t'(lts1[k][31:16])) + int'(eq_pkg::iq_t'(lts2[31:16]));
            sum_q = int'(eq_pkg::iq_t'(lts1[k][15:0])) + int'(eq_pkg::iq_t'(lts2[15:0]));
            est_i[k] = eq_pkg::iq_t'(eq_pkg::LTS_REF[k] ? -(sum_i >>> 1) : (sum_i >>> 1));
            est_q[k] = eq_pkg::iq_t'(eq_pkg::LTS_REF[k] ? -(sum_q >>> 1) : (sum_q >>> 1));
            drive_sample(lts2);
        end
        idle(1);
        reg_read(eq_pkg::REG_STATUS, rdata);
        check_word({name, " STATUS"}, status_word(1'b1), rdata);
    endtask

    task automatic send_data(input int count, input bit enabled);
        logic [31:0] x;
        for (int s = 0; s < count; s++) begin
            for (int k = 0; k < eq_pkg::NUM_SC; k++) begin
                x = {random_iq(), random_iq()};
                if (enabled && eq_pkg::DATA_SC_MASK[k])
                    exp_q.push_back(equalize(x, k));
                drive_sample(x);
            end
            if (enabled)
                symbols++;
            idle($urandom_range(2, 0));
        end
        idle(1);
    endtask

    task automatic drain(input string name);
        int          n;
        logic [31:0] exp_word;
        logic [31:0] got_word;
        n = 0;
        while (!timed_out && got_q.size() < exp_q.size() && n < WAIT_LIMIT) begin
            @(negedge clock);
            n++;
        end
        if (got_q.size() < exp_q.size() && !timed_out) begin
            errors++;
            timed_out = 1'b1;
            $display("timeout: %s got %0d of %0d outputs", name, got_q.size(), exp_q.size());
        end
        // stray strobes would land here
        repeat (4) @(negedge clock);
        check_word({name, " output count"}, exp_q.size(), got_q.size());
        n = 0;
        while (exp_q.size() > 0 && got_q.size() > 0) begin
            exp_word = exp_q.pop_front();
            got_word = got_q.pop_front();
            check_iq($sformatf("%s I[%0d]", name, n), exp_word[31:16], got_word[31:16]);
            check_iq($sformatf("%s Q[%0d]", name, n), exp_word[15:0], got_word[15:0]);
            n++;
        end
        exp_q.delete();
        got_q.delete();
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors == test_errors) begin
            $display("test %0d %s: passed", tests, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: failed, %0d errors", tests, name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    initial begin
        void'($urandom(5247));
        clock        = 1'b0;
        reset        = 1'b1;
        wb_cyc_i     = 1'b0;
        wb_stb_i     = 1'b0;
        wb_we_i      = 1'b0;
        wb_adr_i     = '0;
        wb_dat_i     = '0;
        sample_i     = '0;
        sample_stb_i = 1'b0;
        scale        = eq_pkg::SCALE_RESET;
        symbols      = 0;
        errors       = 0;
        test_errors  = 0;
        tests        = 0;
        failed_tests = 0;
        timed_out    = 1'b0;
        repeat (2) @(negedge clock);
        reset = 1'b0;

        reg_read(eq_pkg::REG_STATUS, rdata);
        check_word("reset STATUS", 32'd0, rdata);
        reg_read(eq_pkg::REG_SCALE, rdata);
        check_word("reset SCALE", 32'(eq_pkg::SCALE_RESET), rdata);
        reg_read(eq_pkg::REG_CTRL, rdata);
        check_word("reset CTRL", 32'd0, rdata);
        // any shift but the reset value
        scale = eq_pkg::scale_t'($urandom_range(12, 9));
        reg_write(eq_pkg::REG_SCALE, 32'(scale));
        reg_read(eq_pkg::REG_SCALE, rdata);
        check_word("SCALE readback", 32'(scale), rdata);
        finish_test("reset_values");

        reg_write(eq_pkg::REG_CTRL, 32'd1);
        train("training");
        send_data(4, 1'b1);
        drain("equalize");
        finish_test("equalize");

        for (int s = 0; s < 3; s++) begin
            // a step of 1 to 15 always lands on a new shift
            scale = scale + eq_pkg::scale_t'($urandom_range(15, 1));
            reg_write(eq_pkg::REG_SCALE, 32'(scale));
            send_data(1, 1'b1);
            drain($sformatf("scale %0d", scale));
        end
        finish_test("scale");

        reg_write(eq_pkg::REG_CTRL, 32'd0);
        send_data(2, 1'b0);
        drain("disabled");
        reg_read(eq_pkg::REG_STATUS, rdata);
        check_word("disabled STATUS", status_word(1'b1), rdata);
        reg_write(eq_pkg::REG_CTRL, 32'd1);
        send_data(2, 1'b1);
        drain("re-enabled");
        finish_test("enable");

        reg_write(eq_pkg::REG_CTRL, 32'd3);
        reg_read(eq_pkg::REG_STATUS, rdata);
        check_word("restart STATUS", status_word(1'b0), rdata);
        reg_read(eq_pkg::REG_CTRL, rdata);
        check_word("restart CTRL", 32'd1, rdata);
        train("retraining");
        send_data(2, 1'b1);
        drain("retrained");
        finish_test("restart");

        // enough symbols to wrap the 8-bit count
        send_data(250, 1'b1);
        drain("long run");
        reg_read(eq_pkg::REG_STATUS, rdata);
        check_word("symbol count", status_word(1'b1), rdata);
        finish_test("symbol_count");

        $display("%0d tests, %0d failed, %0d errors, %0d assertion failures",
                 tests, failed_tests, errors, DUT.u_asserts.fail_count);
        if (errors == 0 && DUT.u_asserts.fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
